// ==== design/scatter_fmt_pkg.sv ====
`default_nettype none

package scatter_fmt_pkg;

  // Lanes per tensor vector
  localparam int NUM_LANES = 8;

  // Input lanes and high lanes keep full precision
  localparam int PRECISION = 16;

  // Requantized low lanes
  localparam int LOW_BITS = 8;

  // Statistics counters wrap at this width
  localparam int CNT_BITS = 32;

  // Enough bits to count 0..NUM_LANES lanes
  localparam int LANE_CNT_BITS = $clog2(NUM_LANES + 1);

  // One signed full-precision lane
  typedef logic signed [PRECISION-1:0] lane_t;

  // One signed requantized lane
  typedef logic signed [LOW_BITS-1:0] low_lane_t;

  // One flag per lane, bit i belongs to lane i
  typedef logic [NUM_LANES-1:0] lane_mask_t;

endpackage

`default_nettype wire

// ==== design/scatter_stream_pkg.sv ====
`default_nettype none

package scatter_stream_pkg;

  import scatter_fmt_pkg::*;

  // Whole vector, lane 0 in the low bits
  typedef lane_t [NUM_LANES-1:0] scatter_vec_t;

  // Output record of stage 2
  typedef struct packed {
    // Full-precision outliers, zero in low lanes
    scatter_vec_t high;
    // Requantized lanes, zero where the lane went high
    low_lane_t [NUM_LANES-1:0] low;
    // Lanes that were routed high
    lane_mask_t mask;
  } scatter_out_t;

  // Stage 1 side info for the control block
  typedef struct packed {
    // Lanes over threshold
    logic [LANE_CNT_BITS-1:0] req_cnt;
    // Lanes that got a high slot
    logic [LANE_CNT_BITS-1:0] kept_cnt;
  } split_info_t;

  // Running totals since reset
  typedef struct packed {
    logic [CNT_BITS-1:0] vectors;
    logic [CNT_BITS-1:0] kept;
    logic [CNT_BITS-1:0] dropped;
  } scatter_stats_t;

endpackage

`default_nettype wire

// ==== design/priority_encoder.sv ====
`default_nettype none

module priority_encoder #(
  parameter int NUM_INPUT_CHANNELS = 8,
  parameter int NO_INDICIES = 2
) (
  // Only samples the assertions
  input wire logic clk,
  input wire scatter_fmt_pkg::lane_mask_t input_channels,
  output scatter_fmt_pkg::lane_mask_t mask
);

  // Lowest index wins until the slots run out
  always_comb begin
    int granted;
    granted = 0;
    mask = '0;
    for (int chan = 0; chan < NUM_INPUT_CHANNELS; chan++) begin
      if (input_channels[chan] && (granted < NO_INDICIES)) begin
        mask[chan] = 1'b1;
        granted++;
      end
    end
  end

  // Grants only where requested
  a_mask_subset: assert property (
    @(posedge clk) (mask & ~input_channels) == '0
  );

  // Never more grants than slots
  a_mask_slots: assert property (
    @(posedge clk) $countones(mask) <= NO_INDICIES
  );

endmodule

`default_nettype wire

// ==== design/array_zero_mask.sv ====
`default_nettype none

module array_zero_mask (
  input wire scatter_stream_pkg::scatter_vec_t data,
  input wire scatter_fmt_pkg::lane_mask_t mask,
  // Masked-in lanes
  output scatter_stream_pkg::scatter_vec_t data_out_0,
  // Masked-out lanes
  output scatter_stream_pkg::scatter_vec_t data_out_1
);

  import scatter_fmt_pkg::*;

  // Each lane goes to exactly one side
  // the other side sees zero in that lane
  always_comb begin
    for (int lane = 0; lane < NUM_LANES; lane++) begin
      if (mask[lane]) begin
        // Selected lane
        data_out_0[lane] = data[lane];
        data_out_1[lane] = '0;
      end else begin
        // Unselected lane
        data_out_0[lane] = '0;
        data_out_1[lane] = data[lane];
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/scatter_threshold.sv ====
`default_nettype none

module scatter_threshold #(
  parameter int HIGH_SLOTS = 2
) (
  input wire logic clk,
  input wire logic rst_n,
  input wire scatter_stream_pkg::scatter_vec_t data_in,
  input wire scatter_fmt_pkg::lane_t threshold,
  output scatter_stream_pkg::scatter_vec_t s1_high,
  output scatter_stream_pkg::scatter_vec_t s1_low,
  output scatter_fmt_pkg::lane_mask_t s1_mask,
  output scatter_stream_pkg::split_info_t s1_info
);

  import scatter_fmt_pkg::*;
  import scatter_stream_pkg::*;

  // Set lanes in a mask
  function automatic logic [LANE_CNT_BITS-1:0] count_lanes(input lane_mask_t bits);
    logic [LANE_CNT_BITS-1:0] total;
    total = '0;
    for (int lane = 0; lane < NUM_LANES; lane++) begin
      total = total + LANE_CNT_BITS'(bits[lane]);
    end
    return total;
  endfunction

  lane_mask_t req_vec;
  lane_mask_t keep_mask;
  scatter_vec_t high_vec;
  scatter_vec_t low_vec;

  // Outlier if beyond +threshold or below -threshold, signed compare
  always_comb begin
    for (int lane = 0; lane < NUM_LANES; lane++) begin
      req_vec[lane] = ($signed(data_in[lane]) > threshold) ||
                      ($signed(data_in[lane]) < -threshold);
    end
  end

  // Keep the first HIGH_SLOTS outliers
  priority_encoder #(
    .NUM_INPUT_CHANNELS(NUM_LANES),
    .NO_INDICIES(HIGH_SLOTS)
  ) i_priority_encoder (
    .clk(clk),
    .input_channels(req_vec),
    .mask(keep_mask)
  );

  // Steer kept lanes high, the rest low
  array_zero_mask i_array_zero_mask (
    .data(data_in),
    .mask(keep_mask),
    .data_out_0(high_vec),
    .data_out_1(low_vec)
  );

  // Stage 1 payload, validity lives in the control block
  always_ff @(posedge clk) begin
    s1_high <= high_vec;
    s1_low <= low_vec;
  end

  // Stage 1 mask and counts
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      s1_mask <= '0;
      s1_info <= '0;
    end else begin
      s1_mask <= keep_mask;
      s1_info.req_cnt <= count_lanes(req_vec);
      s1_info.kept_cnt <= count_lanes(keep_mask);
    end
  end

  // Kept lanes are a subset of the requests
  a_kept_le_req: assert property (
    @(posedge clk) disable iff (!rst_n) s1_info.kept_cnt <= s1_info.req_cnt
  );

endmodule

`default_nettype wire

// ==== design/lane_quantizer.sv ====
`default_nettype none

module lane_quantizer #(
  parameter int QUANT_SHIFT = 4
) (
  input wire logic clk,
  input wire logic rst_n,
  input wire scatter_stream_pkg::scatter_vec_t s1_high,
  input wire scatter_stream_pkg::scatter_vec_t s1_low,
  input wire scatter_fmt_pkg::lane_mask_t s1_mask,
  output scatter_stream_pkg::scatter_out_t out_data
);

  import scatter_fmt_pkg::*;

  // One guard bit so the rounding add cannot wrap
  localparam int SUM_BITS = PRECISION + 1;
  // Half an output step
  localparam logic signed [SUM_BITS-1:0] ROUND_BIAS = SUM_BITS'(1 << (QUANT_SHIFT - 1));
  // Signed 8-bit range
  localparam logic signed [SUM_BITS-1:0] LOW_MAX = SUM_BITS'((1 << (LOW_BITS - 1)) - 1);
  localparam logic signed [SUM_BITS-1:0] LOW_MIN = -SUM_BITS'(1 << (LOW_BITS - 1));

  low_lane_t [NUM_LANES-1:0] quant;
  // Routed-high lanes that still carry a low value
  lane_mask_t low_on_mask;

  // Round half up, arithmetic shift, then clamp
  always_comb begin
    logic signed [SUM_BITS-1:0] rounded;
    logic signed [SUM_BITS-1:0] shifted;
    for (int lane = 0; lane < NUM_LANES; lane++) begin
      // Sign extend before the add
      rounded = $signed({s1_low[lane][PRECISION-1], s1_low[lane]}) + ROUND_BIAS;
      shifted = rounded >>> QUANT_SHIFT;
      if (shifted > LOW_MAX) begin
        quant[lane] = LOW_MAX[LOW_BITS-1:0];
      end else if (shifted < LOW_MIN) begin
        quant[lane] = LOW_MIN[LOW_BITS-1:0];
      end else begin
        quant[lane] = shifted[LOW_BITS-1:0];
      end
    end
  end

  // Stage 2 payload
  always_ff @(posedge clk) begin
    out_data.high <= s1_high;
    out_data.low <= quant;
  end

  // Stage 2 mask
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_data.mask <= '0;
    end else begin
      out_data.mask <= s1_mask;
    end
  end

  always_comb begin
    for (int lane = 0; lane < NUM_LANES; lane++) begin
      low_on_mask[lane] = out_data.mask[lane] && (out_data.low[lane] != '0);
    end
  end

  // High lanes never appear in the low vector
  a_low_zero_on_mask: assert property (
    @(posedge clk) disable iff (!rst_n) low_on_mask == '0
  );

endmodule

`default_nettype wire

// ==== design/scatter_ctrl.sv ====
`default_nettype none

module scatter_ctrl #(
  parameter scatter_fmt_pkg::lane_t RESET_THRESHOLD = 6
) (
  input wire logic clk,
  input wire logic rst_n,
  input wire logic in_valid,
  input wire logic cfg_valid,
  input wire scatter_fmt_pkg::lane_t cfg_threshold,
  input wire scatter_stream_pkg::split_info_t s1_info,
  output scatter_fmt_pkg::lane_t threshold,
  output logic out_valid,
  output scatter_stream_pkg::scatter_stats_t stats
);

  import scatter_fmt_pkg::*;

  // Stage 1 holds a real vector
  logic s1_valid;

  // New threshold takes effect for the next vector
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      threshold <= RESET_THRESHOLD;
    end else if (cfg_valid) begin
      threshold <= cfg_threshold;
    end
  end

  // Valid follows the two data stages
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      s1_valid <= in_valid;
      out_valid <= s1_valid;
    end
  end

  // Counters wrap silently
  // only stage 1 info of a valid vector is counted
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      stats <= '0;
    end else if (s1_valid) begin
      stats.vectors <= stats.vectors + 1'b1;
      stats.kept <= stats.kept + CNT_BITS'(s1_info.kept_cnt);
      // Outliers beyond the slot limit
      stats.dropped <= stats.dropped +
                       CNT_BITS'(s1_info.req_cnt - s1_info.kept_cnt);
    end
  end

  // Nothing leaves the pipe right after reset
  a_no_valid_after_reset: assert property (
    @(posedge clk) !rst_n |=> !out_valid
  );

  // A loaded threshold must be non-negative
  a_cfg_non_negative: assert property (
    @(posedge clk) disable iff (!rst_n) cfg_valid |=> !threshold[PRECISION-1]
  );

endmodule

`default_nettype wire

// ==== design/outlier_scatter_top.sv ====
`default_nettype none

module outlier_scatter_top #(
  parameter int HIGH_SLOTS = 2,
  parameter scatter_fmt_pkg::lane_t RESET_THRESHOLD = 6,
  parameter int QUANT_SHIFT = 4
) (
  input wire logic clk,
  input wire logic rst_n,
  // One pulse per vector
  input wire logic in_valid,
  input wire scatter_stream_pkg::scatter_vec_t in_vec,
  // Threshold load
  input wire logic cfg_valid,
  input wire scatter_fmt_pkg::lane_t cfg_threshold,
  // Two cycles after in_valid
  output logic out_valid,
  output scatter_stream_pkg::scatter_out_t out_data,
  output scatter_stream_pkg::scatter_stats_t stats
);

  import scatter_fmt_pkg::*;
  import scatter_stream_pkg::*;

  // Current threshold from control
  lane_t threshold;
  // Stage 1 split
  scatter_vec_t s1_high;
  scatter_vec_t s1_low;
  lane_mask_t s1_mask;
  split_info_t s1_info;

  // Threshold, valid tracking, statistics
  scatter_ctrl #(
    .RESET_THRESHOLD(RESET_THRESHOLD)
  ) i_scatter_ctrl (
    .clk(clk),
    .rst_n(rst_n),
    .in_valid(in_valid),
    .cfg_valid(cfg_valid),
    .cfg_threshold(cfg_threshold),
    .s1_info(s1_info),
    .threshold(threshold),
    .out_valid(out_valid),
    .stats(stats)
  );

  // Stage 1, outlier detection and split
  scatter_threshold #(
    .HIGH_SLOTS(HIGH_SLOTS)
  ) i_scatter_threshold (
    .clk(clk),
    .rst_n(rst_n),
    .data_in(in_vec),
    .threshold(threshold),
    .s1_high(s1_high),
    .s1_low(s1_low),
    .s1_mask(s1_mask),
    .s1_info(s1_info)
  );

  // Stage 2, requantize the low side
  lane_quantizer #(
    .QUANT_SHIFT(QUANT_SHIFT)
  ) i_lane_quantizer (
    .clk(clk),
    .rst_n(rst_n),
    .s1_high(s1_high),
    .s1_low(s1_low),
    .s1_mask(s1_mask),
    .out_data(out_data)
  );

endmodule

`default_nettype wire

// ==== dv/outlier_scatter_tb.sv ====
`default_nettype none

module outlier_scatter_tb;

  import scatter_fmt_pkg::*;
  import scatter_stream_pkg::*;

  // DUT configuration
  localparam int HIGH_SLOTS = 2;
  localparam int RESET_THRESHOLD = 6;
  localparam int QUANT_SHIFT = 4;
  // Cycles allowed for the pipe to empty
  localparam int DRAIN_LIMIT = 20;

  logic clk;
  logic rst_n;
  logic in_valid;
  scatter_vec_t in_vec;
  logic cfg_valid;
  lane_t cfg_threshold;
  logic out_valid;
  scatter_out_t out_data;
  scatter_stats_t stats;

  integer seed;
  string cur_test;
  int errors;
  int checks;
  int tests;
  int test_err_base;
  // Expected records in issue order
  scatter_out_t exp_q[$];
  // Last record seen by the checker
  scatter_out_t last_out;
  // Model state
  int model_thr;
  int model_vectors;
  int model_kept;
  int model_dropped;

  outlier_scatter_top #(
    .HIGH_SLOTS(HIGH_SLOTS),
    .RESET_THRESHOLD(RESET_THRESHOLD),
    .QUANT_SHIFT(QUANT_SHIFT)
  ) i_outlier_scatter_top (
    .clk(clk),
    .rst_n(rst_n),
    .in_valid(in_valid),
    .in_vec(in_vec),
    .cfg_valid(cfg_valid),
    .cfg_threshold(cfg_threshold),
    .out_valid(out_valid),
    .out_data(out_data),
    .stats(stats)
  );

  always #20 clk = ~clk;

  // Reference split with outlier test, slot limit, rounding shift and clamp
  task automatic model_split(input scatter_vec_t vec, input int thr,
                             output scatter_out_t res, output int req, output int kept);
    int v;
    int q;
    res = '0;
    req = 0;
    kept = 0;
    for (int lane = 0; lane < NUM_LANES; lane++) begin
      v = $signed(vec[lane]);
      if (v > thr || v < -thr) begin
        req++;
        // Lowest lanes claim the slots
        if (kept < HIGH_SLOTS) begin
          kept++;
          res.mask[lane] = 1'b1;
          res.high[lane] = vec[lane];
        end
      end
      if (!res.mask[lane]) begin
        q = (v + (1 << (QUANT_SHIFT - 1))) >>> QUANT_SHIFT;
        if (q > 127) q = 127;
        if (q < -128) q = -128;
        res.low[lane] = low_lane_t'(q);
      end
    end
  endtask

  // Mostly small lanes, some medium, a few full range
  function automatic lane_t random_lane();
    int sel;
    int r;
    sel = $random(seed) & 7;
    r = $random(seed);
    if (sel < 4) return lane_t'(r % 9);
    if (sel < 7) return lane_t'(r % 301);
    return lane_t'(r);
  endfunction

  function automatic scatter_vec_t random_vec();
    scatter_vec_t vec;
    for (int lane = 0; lane < NUM_LANES; lane++) begin
      vec[lane] = random_lane();
    end
    return vec;
  endfunction

  // One input cycle with the model on the DUT's threshold timing
  task automatic send(input logic valid, input scatter_vec_t vec,
                      input logic cfg, input int cfg_thr);
    scatter_out_t expected;
    int req;
    int kept;
    @(posedge clk);
    #2;
    in_valid = valid;
    in_vec = vec;
    cfg_valid = cfg;
    cfg_threshold = lane_t'(cfg_thr);
    if (valid) begin
      // Vector sampled with the old threshold
      model_split(vec, model_thr, expected, req, kept);
      exp_q.push_back(expected);
      model_vectors++;
      model_kept += kept;
      model_dropped += req - kept;
    end
    if (cfg) model_thr = cfg_thr;
  endtask

  // Stop driving and wait until every vector came out
  task automatic drain();
    int cyc;
    cyc = 0;
    @(posedge clk);
    #2;
    in_valid = 1'b0;
    cfg_valid = 1'b0;
    while (exp_q.size() != 0 && cyc < DRAIN_LIMIT) begin
      @(posedge clk);
      cyc++;
    end
    if (exp_q.size() != 0) begin
      errors++;
      $display("ERROR: %s: timed out waiting for out_valid, %0d vectors still in flight",
               cur_test, exp_q.size());
      exp_q.delete();
    end
  endtask

  task automatic check_value(input string what, input longint expected, input longint actual);
    checks++;
    if (expected != actual) begin
      errors++;
      $display("[FAIL] %s %s: expected %0d actual %0d", cur_test, what, expected, actual);
    end
  endtask

  task automatic start_test(input string name);
    cur_test = name;
    test_err_base = errors;
    tests++;
  endtask

  task automatic end_test();
    $display("test %-10s %s, %0d errors", cur_test,
             (errors == test_err_base) ? "ok" : "failed", errors - test_err_base);
  endtask

  // Outputs settle well before the falling edge
  always @(negedge clk) begin
    scatter_out_t expected;
    if (rst_n && out_valid) begin
      checks++;
      last_out = out_data;
      if (exp_q.size() == 0) begin
        errors++;
        $display("ERROR: %s: out_valid went high with no vector in flight", cur_test);
      end else begin
        expected = exp_q.pop_front();
        if (out_data !== expected) begin
          errors++;
          $display("[FAIL] %s: out_data expected %h actual %h", cur_test, expected, out_data);
        end
      end
    end
  end

  initial begin
    scatter_vec_t vec;
    int lat;
    logic seen;
    clk = 1'b0;
    rst_n = 1'b0;
    in_valid = 1'b0;
    in_vec = '0;
    cfg_valid = 1'b0;
    cfg_threshold = '0;
    seed = 32'hb296;
    errors = 0;
    checks = 0;
    tests = 0;
    last_out = '0;
    model_thr = RESET_THRESHOLD;
    model_vectors = 0;
    model_kept = 0;
    model_dropped = 0;
    cur_test = "reset";
    repeat (8) @(posedge clk);
    #2;
    rst_n = 1'b1;

    // Idle outputs, then the exact threshold boundary
    start_test("reset");
    @(negedge clk);
    check_value("out_valid", 0, out_valid);
    check_value("stats.vectors", 0, stats.vectors);
    check_value("stats.kept", 0, stats.kept);
    check_value("stats.dropped", 0, stats.dropped);
    for (int lane = 0; lane < NUM_LANES; lane++) begin
      vec[lane] = (lane % 2) ? lane_t'(-RESET_THRESHOLD) : lane_t'(RESET_THRESHOLD);
    end
    send(1'b1, vec, 1'b0, 0);
    drain();
    check_value("mask at threshold", 0, last_out.mask);
    for (int lane = 0; lane < NUM_LANES; lane++) begin
      vec[lane] = (lane % 2) ? lane_t'(-RESET_THRESHOLD - 1) : lane_t'(RESET_THRESHOLD + 1);
    end
    send(1'b1, vec, 1'b0, 0);
    drain();
    // Every lane is over and only the lowest slots win
    check_value("mask over threshold", (1 << HIGH_SLOTS) - 1, last_out.mask);
    end_test();

    // Single vector latency counted from its in_valid cycle
    start_test("latency");
    send(1'b1, random_vec(), 1'b0, 0);
    @(posedge clk);
    #2;
    in_valid = 1'b0;
    lat = 1;
    seen = 1'b0;
    while (!seen && lat < 10) begin
      @(negedge clk);
      if (out_valid) seen = 1'b1;
      else lat++;
    end
    if (!seen) begin
      errors++;
      $display("ERROR: %s: out_valid never rose after a single vector", cur_test);
    end else begin
      check_value("cycles to out_valid", 2, lat);
    end
    drain();
    end_test();

    // Random stream with gaps
    start_test("stream");
    for (int cyc = 0; cyc < 300; cyc++) begin
      if (cyc % 60 == 59) begin
        repeat (3) send(1'b0, '0, 1'b0, 0);
      end else begin
        send(($random(seed) & 3) != 0, random_vec(), 1'b0, 0);
      end
    end
    drain();
    end_test();

    // Late outliers beyond the slots saturate in the low vector
    start_test("overflow");
    vec[0] = 16'sd3000;
    vec[1] = 16'sd2;
    vec[2] = -16'sd4000;
    vec[3] = 16'sd9000;
    vec[4] = -16'sd9000;
    vec[5] = 16'sd1;
    vec[6] = 16'sd2500;
    vec[7] = -16'sd3000;
    send(1'b1, vec, 1'b0, 0);
    drain();
    check_value("mask", 8'b0000_0101, last_out.mask);
    check_value("low lane 3", 127, $signed(last_out.low[3]));
    check_value("low lane 4", -128, $signed(last_out.low[4]));
    check_value("low lane 7", -128, $signed(last_out.low[7]));
    // Full-range lanes are nearly all outliers
    for (int n = 0; n < 30; n++) begin
      for (int lane = 0; lane < NUM_LANES; lane++) begin
        vec[lane] = lane_t'($random(seed));
      end
      send(1'b1, vec, 1'b0, 0);
    end
    drain();
    end_test();

    // Threshold reload alone and together with a vector
    start_test("config");
    send(1'b0, '0, 1'b1, 150);
    for (int n = 0; n < 40; n++) begin
      send(1'b1, random_vec(), 1'b0, 0);
    end
    // This vector still uses 150
    send(1'b1, random_vec(), 1'b1, 0);
    for (int n = 0; n < 20; n++) begin
      send(1'b1, random_vec(), 1'b0, 0);
    end
    send(1'b0, '0, 1'b1, 150);
    vec = '0;
    vec[0] = 16'sd150;
    vec[1] = -16'sd150;
    vec[2] = 16'sd151;
    vec[3] = -16'sd151;
    send(1'b1, vec, 1'b0, 0);
    drain();
    check_value("mask at new threshold", 8'b0000_1100, last_out.mask);
    send(1'b0, '0, 1'b1, RESET_THRESHOLD);
    drain();
    end_test();

    // Totals against the model
    start_test("stats");
    @(posedge clk);
    @(negedge clk);
    check_value("stats.vectors", model_vectors, stats.vectors);
    check_value("stats.kept", model_kept, stats.kept);
    check_value("stats.dropped", model_dropped, stats.dropped);
    end_test();

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== outlier_scatter.f ====
design/scatter_fmt_pkg.sv
design/scatter_stream_pkg.sv
design/priority_encoder.sv
design/array_zero_mask.sv
design/scatter_threshold.sv
design/lane_quantizer.sv
design/scatter_ctrl.sv
design/outlier_scatter_top.sv
dv/outlier_scatter_tb.sv
